//--- run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module zynq_dram_shell_tb \
   -f zynq_dram_shell.f -o zynq_dram_shell_sim \
   && ./obj_dir/zynq_dram_shell_sim \
   || exit 1

//--- zynq_dram_shell.f
zynq_dram_shell_pkg.sv
zynq_dram_shell_csr.sv
zynq_dram_shell_xlate.sv
zynq_dram_shell_profiler.sv
zynq_dram_shell_top.sv
zynq_dram_shell_clkgen.sv
zynq_dram_shell_assertions.sv
zynq_dram_shell_tb.sv

//--- zynq_dram_shell_assertions.sv
`default_nettype none

module zynq_dram_shell_assertions (
   input wire logic                                            aclk,
   input wire logic                                            reset_i,
   input wire logic                                            core_reset_i,
   input wire logic [zynq_dram_shell_pkg::axil_addr_width-1:0] awaddr_i,
   input wire logic                                            wdata_run_i,
   input wire logic                                            wstrb_run_i,
   input wire logic                                            wr_fire_i,
   input wire logic                                            bvalid_i,
   input wire logic                                            rvalid_i,
   input wire logic                                            req_ready_i,
   input wire logic                                            mem_valid_i,
   input wire logic                                            mem_ready_i,
   input wire logic [31:0]                                     mem_addr_i,
   input wire logic                                            mem_op_i
);

   logic run_r;

   // shadow of the run bit, rebuilt from the host writes to its offset
   always_ff @(posedge aclk) begin
      if (reset_i) begin
         run_r <= 1'b0;
      end else if (wr_fire_i && (awaddr_i == zynq_dram_shell_pkg::reg_core_run) &&
                   wstrb_run_i) begin
         run_r <= wdata_run_i;
      end
   end

   // a held memory request keeps its payload until taken, unless the core is reset
   property mem_hold_p;
      @(posedge aclk) disable iff (core_reset_i)
         (mem_valid_i && !mem_ready_i) |=>
            (mem_valid_i && $stable(mem_addr_i) && $stable(mem_op_i));
   endproperty

   mem_hold_a: assert property (mem_hold_p)
      else $error("memory request changed before it was taken");

   resp_after_reset_a: assert property (@(posedge aclk) $fell(reset_i) |-> (!bvalid_i && !rvalid_i))
      else $error("AXI response valid right after reset");

   ready_when_stopped_a: assert property (@(posedge aclk) !run_r |-> !req_ready_i)
      else $error("request ready while the core is stopped");

endmodule

bind zynq_dram_shell_top zynq_dram_shell_assertions chk (
   .aclk         (aclk),
   .reset_i      (reset_i),
   .core_reset_i (core_reset),
   .awaddr_i     (s_axil_awaddr_i),
   .wdata_run_i  (s_axil_wdata_i[0]),
   .wstrb_run_i  (s_axil_wstrb_i[0]),
   .wr_fire_i    (s_axil_awvalid_i && s_axil_awready_o && s_axil_wvalid_i && s_axil_wready_o),
   .bvalid_i     (s_axil_bvalid_o),
   .rvalid_i     (s_axil_rvalid_o),
   .req_ready_i  (req_ready_o),
   .mem_valid_i  (mem_valid_o),
   .mem_ready_i  (mem_ready_i),
   .mem_addr_i   (mem_addr_o),
   .mem_op_i     (mem_op_o)
);

`default_nettype wire

//--- zynq_dram_shell_clkgen.sv
`default_nettype none

module zynq_dram_shell_clkgen (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #10 clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

//--- zynq_dram_shell_csr.sv
`default_nettype none

module zynq_dram_shell_csr (
   input  wire logic                                             aclk,
   input  wire logic                                             reset_i,
   input  wire logic [zynq_dram_shell_pkg::axil_addr_width-1:0]  s_axil_awaddr_i,
   input  wire logic                                             s_axil_awvalid_i,
   output logic                                                  s_axil_awready_o,
   input  wire logic [zynq_dram_shell_pkg::axil_data_width-1:0]  s_axil_wdata_i,
   input  wire logic [zynq_dram_shell_pkg::axil_data_width/8-1:0] s_axil_wstrb_i,
   input  wire logic                                             s_axil_wvalid_i,
   output logic                                                  s_axil_wready_o,
   output logic [1:0]                                            s_axil_bresp_o,
   output logic                                                  s_axil_bvalid_o,
   input  wire logic                                             s_axil_bready_i,
   input  wire logic [zynq_dram_shell_pkg::axil_addr_width-1:0]  s_axil_araddr_i,
   input  wire logic                                             s_axil_arvalid_i,
   output logic                                                  s_axil_arready_o,
   output logic [zynq_dram_shell_pkg::axil_data_width-1:0]       s_axil_rdata_o,
   output logic [1:0]                                            s_axil_rresp_o,
   output logic                                                  s_axil_rvalid_o,
   input  wire logic                                             s_axil_rready_i,
   input  wire logic [zynq_dram_shell_pkg::region_count-1:0]     region_map_i,
   input  wire logic [zynq_dram_shell_pkg::high_count_width-1:0] high_count_i,
   output logic                                                  core_reset_o,
   output logic                                                  dram_alloc_o,
   output logic [zynq_dram_shell_pkg::dram_addr_width-1:0]       dram_base_o,
   output logic                                                  count_en_o
);

   zynq_dram_shell_pkg::axil_state_e state_r;

   logic [zynq_dram_shell_pkg::axil_data_width-1:0] core_run_r;
   logic [zynq_dram_shell_pkg::axil_data_width-1:0] dram_alloc_r;
   logic [zynq_dram_shell_pkg::axil_data_width-1:0] dram_base_r;
   logic [zynq_dram_shell_pkg::axil_data_width-1:0] count_en_r;
   logic [zynq_dram_shell_pkg::axil_data_width-1:0] rd_mux;
   logic [zynq_dram_shell_pkg::axil_data_width-1:0] rdata_r;
   logic                                            wr_fire;
   logic                                            rd_fire;

   // replace only the bytes whose strobe is set
   function automatic logic [zynq_dram_shell_pkg::axil_data_width-1:0] merge_bytes(
      input logic [zynq_dram_shell_pkg::axil_data_width-1:0]   old_val,
      input logic [zynq_dram_shell_pkg::axil_data_width-1:0]   new_val,
      input logic [zynq_dram_shell_pkg::axil_data_width/8-1:0] strb
   );
      logic [zynq_dram_shell_pkg::axil_data_width-1:0] res;
      res = old_val;
      for (int i = 0; i < zynq_dram_shell_pkg::axil_data_width / 8; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return res;
   endfunction

   // address and data of a write are taken in the same cycle
   assign wr_fire = (state_r == zynq_dram_shell_pkg::idle) && s_axil_awvalid_i && s_axil_wvalid_i;
   // a pending write wins over a read offered at the same time
   assign rd_fire = (state_r == zynq_dram_shell_pkg::idle) && s_axil_arvalid_i &&
                    !(s_axil_awvalid_i && s_axil_wvalid_i);

   assign s_axil_awready_o = wr_fire;
   assign s_axil_wready_o  = wr_fire;
   assign s_axil_arready_o = rd_fire;

   assign s_axil_bvalid_o = (state_r == zynq_dram_shell_pkg::write_resp);
   assign s_axil_rvalid_o = (state_r == zynq_dram_shell_pkg::read_data);
   assign s_axil_bresp_o  = zynq_dram_shell_pkg::axil_resp_okay;
   assign s_axil_rresp_o  = zynq_dram_shell_pkg::axil_resp_okay;
   assign s_axil_rdata_o  = rdata_r;

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         state_r <= zynq_dram_shell_pkg::idle;
      end else begin
         case (state_r)
            zynq_dram_shell_pkg::idle: begin
               if (wr_fire) begin
                  state_r <= zynq_dram_shell_pkg::write_resp;
               end else if (rd_fire) begin
                  state_r <= zynq_dram_shell_pkg::read_data;
               end
            end
            zynq_dram_shell_pkg::write_resp: begin
               if (s_axil_bready_i) begin
                  state_r <= zynq_dram_shell_pkg::idle;
               end
            end
            zynq_dram_shell_pkg::read_data: begin
               if (s_axil_rready_i) begin
                  state_r <= zynq_dram_shell_pkg::idle;
               end
            end
            default: begin
               state_r <= zynq_dram_shell_pkg::idle;
            end
         endcase
      end
   end

   // writes to the result registers or unmapped offsets fall through
   always_ff @(posedge aclk) begin
      if (reset_i) begin
         core_run_r   <= '0;
         dram_alloc_r <= '0;
         dram_base_r  <= '0;
         count_en_r   <= '0;
      end else if (wr_fire) begin
         case (s_axil_awaddr_i)
            zynq_dram_shell_pkg::reg_core_run:
               core_run_r <= merge_bytes(core_run_r, s_axil_wdata_i, s_axil_wstrb_i);
            zynq_dram_shell_pkg::reg_dram_alloc:
               dram_alloc_r <= merge_bytes(dram_alloc_r, s_axil_wdata_i, s_axil_wstrb_i);
            zynq_dram_shell_pkg::reg_dram_base:
               dram_base_r <= merge_bytes(dram_base_r, s_axil_wdata_i, s_axil_wstrb_i);
            zynq_dram_shell_pkg::reg_count_en:
               count_en_r <= merge_bytes(count_en_r, s_axil_wdata_i, s_axil_wstrb_i);
            default: begin
            end
         endcase
      end
   end

   always_comb begin
      case (s_axil_araddr_i)
         zynq_dram_shell_pkg::reg_core_run:   rd_mux = core_run_r;
         zynq_dram_shell_pkg::reg_dram_alloc: rd_mux = dram_alloc_r;
         zynq_dram_shell_pkg::reg_dram_base:  rd_mux = dram_base_r;
         zynq_dram_shell_pkg::reg_count_en:   rd_mux = count_en_r;
         zynq_dram_shell_pkg::reg_region_0:   rd_mux = region_map_i[31:0];
         zynq_dram_shell_pkg::reg_region_1:   rd_mux = region_map_i[63:32];
         zynq_dram_shell_pkg::reg_region_2:   rd_mux = region_map_i[95:64];
         zynq_dram_shell_pkg::reg_region_3:   rd_mux = region_map_i[127:96];
         zynq_dram_shell_pkg::reg_high_count:
            rd_mux = zynq_dram_shell_pkg::axil_data_width'(high_count_i);
         default:                             rd_mux = '0;
      endcase
   end

   always_ff @(posedge aclk) begin
      if (rd_fire) begin
         rdata_r <= rd_mux;
      end
   end

   // the core is held in reset until the host sets the run bit
   assign core_reset_o = reset_i | ~core_run_r[0];
   assign dram_alloc_o = dram_alloc_r[0];
   assign dram_base_o  = dram_base_r;
   assign count_en_o   = count_en_r[0];

endmodule

`default_nettype wire

//--- zynq_dram_shell_pkg.sv
`default_nettype none

package zynq_dram_shell_pkg;

   localparam int axil_addr_width = 8;
   localparam int axil_data_width = 32;
   localparam int dram_addr_width = 32;

   // the core sees its DRAM at this base; the host allocation replaces it
   localparam logic [dram_addr_width-1:0] dram_window_base = 32'h8000_0000;

   // usage bitmap with one bit per 8 MB region of a 1 GB span
   localparam int region_count = 128;
   localparam int region_msb = 29;
   localparam int region_lsb = 23;

   localparam int high_count_width = 16;
   localparam logic [dram_addr_width-1:0] default_mem_limit = 32'h1000_0000;

   // host-visible register map, byte offsets
   localparam logic [axil_addr_width-1:0] reg_core_run   = 8'h00;
   localparam logic [axil_addr_width-1:0] reg_dram_alloc = 8'h04;
   localparam logic [axil_addr_width-1:0] reg_dram_base  = 8'h08;
   localparam logic [axil_addr_width-1:0] reg_count_en   = 8'h0C;
   localparam logic [axil_addr_width-1:0] reg_region_0   = 8'h10;
   localparam logic [axil_addr_width-1:0] reg_region_1   = 8'h14;
   localparam logic [axil_addr_width-1:0] reg_region_2   = 8'h18;
   localparam logic [axil_addr_width-1:0] reg_region_3   = 8'h1C;
   localparam logic [axil_addr_width-1:0] reg_high_count = 8'h20;

   typedef enum logic [1:0] {
      idle,
      write_resp,
      read_data
   } axil_state_e;

   typedef enum logic {
      op_read,
      op_write
   } mem_op_e;

   localparam logic [1:0] axil_resp_okay = 2'b00;

endpackage

`default_nettype wire

//--- zynq_dram_shell_profiler.sv
`default_nettype none

module zynq_dram_shell_profiler #(
   parameter logic [zynq_dram_shell_pkg::dram_addr_width-1:0] mem_limit =
      zynq_dram_shell_pkg::default_mem_limit
) (
   input  wire logic                                             aclk,
   input  wire logic                                             core_reset_i,
   input  wire logic                                             count_en_i,
   input  wire logic                                             accept_i,
   input  wire logic [zynq_dram_shell_pkg::dram_addr_width-1:0]  accept_addr_i,
   output logic [zynq_dram_shell_pkg::region_count-1:0]          region_map_o,
   output logic [zynq_dram_shell_pkg::high_count_width-1:0]      high_count_o
);

   localparam int region_bits = zynq_dram_shell_pkg::region_msb -
                                zynq_dram_shell_pkg::region_lsb + 1;

   logic [zynq_dram_shell_pkg::region_count-1:0]     region_map_r;
   logic [zynq_dram_shell_pkg::high_count_width-1:0] high_count_r;
   logic [region_bits-1:0]                           region_idx;
   logic [zynq_dram_shell_pkg::dram_addr_width-1:0]  window_offset;
   logic                                             is_high;

   assign region_idx    = accept_addr_i[zynq_dram_shell_pkg::region_msb:
                                        zynq_dram_shell_pkg::region_lsb];
   assign window_offset = accept_addr_i ^ zynq_dram_shell_pkg::dram_window_base;
   // accesses past the allocated DRAM size point at a runaway program
   assign is_high       = (window_offset >= mem_limit);

   always_ff @(posedge aclk) begin
      if (core_reset_i) begin
         region_map_r <= '0;
         high_count_r <= '0;
      end else if (accept_i) begin
         region_map_r[region_idx] <= 1'b1;
         // saturate rather than wrap
         if (count_en_i && is_high && (high_count_r != '1)) begin
            high_count_r <= high_count_r + 1'b1;
         end
      end
   end

   assign region_map_o = region_map_r;
   assign high_count_o = high_count_r;

endmodule

`default_nettype wire

//--- zynq_dram_shell_tb.sv
`default_nettype none

module zynq_dram_shell_tb;

   localparam int planned_txns = 520;
   localparam logic [31:0] window = 32'h8000_0000;
   localparam logic [31:0] limit = 32'h1000_0000;

   logic aclk;
   logic reset_i;
   logic [7:0] awaddr, araddr;
   logic [31:0] wdata;
   logic [3:0] wstrb;
   logic awvalid, wvalid, bready, arvalid, rready;
   logic awready, wready, bvalid, arready, rvalid;
   logic [1:0] bresp, rresp;
   logic [31:0] rdata;
   logic req_valid_i, req_ready_o, mem_valid_o, mem_ready_i;
   logic [31:0] req_addr_i, mem_addr_o;
   zynq_dram_shell_pkg::mem_op_e req_op_i, mem_op_o;

   logic [31:0] seed = 32'd82;
   // back-pressure has its own LCG state
   logic [31:0] ready_seed = 32'd82;
   logic [31:0] model_reg [4];
   logic [127:0] model_map;
   logic [15:0] model_high;
   logic [32:0] exp_q [$];
   logic hold_mem;

   zynq_dram_shell_clkgen clkgen (.clk_o(aclk));

   zynq_dram_shell_top DUT (
      .aclk(aclk), .reset_i(reset_i),
      .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
      .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
      .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
      .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
      .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
      .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
      .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_addr_i(req_addr_i),
      .req_op_i(req_op_i), .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i),
      .mem_addr_o(mem_addr_o), .mem_op_o(mem_op_o)
   );

   // LCG step on the given state; the upper half of two steps avoids the weak low bits
   function automatic logic [31:0] next_rand(inout logic [31:0] state);
      logic [31:0] hi;
      state = state * 32'd1103515245 + 32'd12345;
      hi = {16'h0, state[31:16]};
      state = state * 32'd1103515245 + 32'd12345;
      return {state[31:16], hi[15:0]};
   endfunction

   // host view of a result or unmapped offset according to the model
   function automatic logic [31:0] result_word(input logic [7:0] addr);
      if (addr >= 8'h10 && addr < 8'h20) begin
         return model_map[32 * ((addr - 8'h10) / 4) +: 32];
      end else if (addr == 8'h20) begin
         return 32'(model_high);
      end
      return 32'h0;
   endfunction

   task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      int delay;
      delay = next_rand(seed) % 4;
      @(posedge aclk);
      awaddr <= addr;
      wdata <= data;
      wstrb <= strb;
      awvalid <= 1'b1;
      wvalid <= 1'b1;
      do @(negedge aclk); while (!(awready && wready));
      @(posedge aclk);
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      repeat (delay) @(posedge aclk);
      bready <= 1'b1;
      do @(negedge aclk); while (!bvalid);
      check("bresp", 32'(0), 32'(bresp));
      @(posedge aclk);
      bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
      int delay;
      delay = next_rand(seed) % 4;
      @(posedge aclk);
      araddr <= addr;
      arvalid <= 1'b1;
      do @(negedge aclk); while (!arready);
      @(posedge aclk);
      arvalid <= 1'b0;
      repeat (delay) @(posedge aclk);
      rready <= 1'b1;
      do @(negedge aclk); while (!rvalid);
      check("rresp", 32'(0), 32'(rresp));
      data = rdata;
      @(posedge aclk);
      rready <= 1'b0;
   endtask

   task automatic read_expect(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
      logic [31:0] got;
      axil_read(addr, got);
      check(name, expected, got);
   endtask

   // write a control register and track it in the model
   task automatic ctrl_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
      axil_write(8'(idx * 4), data, strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) model_reg[idx][8*b +: 8] = data[8*b +: 8];
      end
      // the profiler is cleared while the run bit is low
      if (!model_reg[0][0]) begin
         model_map = '0;
         model_high = '0;
      end
   endtask

   // leaves req_valid_i high so that requests can go back to back
   task automatic send_req(input logic [31:0] addr, input logic op);
      logic [31:0] offset;
      @(posedge aclk);
      req_valid_i <= 1'b1;
      req_addr_i <= addr;
      req_op_i <= zynq_dram_shell_pkg::mem_op_e'(op);
      do @(negedge aclk); while (!req_ready_o);
      offset = addr ^ window;
      exp_q.push_back({op, offset + model_reg[2]});
      model_map[addr[29:23]] = 1'b1;
      if (model_reg[3][0] && offset >= limit && model_high != 16'hFFFF) begin
         model_high = model_high + 1'b1;
      end
   endtask

   task automatic send_burst(input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r = next_rand(seed);
         send_req(window | (r[31] ? (r & 32'h0FFF_FFFC) : (r & 32'h7FFF_FFFC)), r[30]);
      end
      @(posedge aclk);
      req_valid_i <= 1'b0;
      wait (exp_q.size() == 0);
   endtask

   task automatic check_profile(input string name);
      for (int w = 0; w < 4; w++) begin
         read_expect(name, 8'(8'h10 + 4 * w), model_map[32*w +: 32]);
      end
      read_expect(name, 8'h20, 32'(model_high));
   endtask

   // memory side with random back-pressure
   always @(posedge aclk) begin
      mem_ready_i <= hold_mem ? 1'b0 : next_rand(ready_seed) % 3 != 0;
   end

   always @(negedge aclk) begin
      if (!reset_i && mem_valid_o && mem_ready_i) begin
         if (exp_q.size() == 0) begin
            $display("memory request appeared with none expected");
            $display("tests failed");
            $fatal(1);
         end
         check("mem_addr", exp_q[0][31:0], mem_addr_o);
         check("mem_op", 32'(exp_q[0][32]), 32'(mem_op_o));
         void'(exp_q.pop_front());
      end
   end

   initial begin
      #(planned_txns * 200 * 20 + 20000);
      $display("watchdog expired before the tests finished");
      $display("tests failed");
      $fatal(1);
   end

   initial begin
      logic [31:0] r;
      logic [7:0] ro_addr;
      reset_i = 1'b1;
      {awvalid, wvalid, bready, arvalid, rready} = '0;
      awaddr = '0;
      araddr = '0;
      wdata = '0;
      wstrb = '0;
      req_valid_i = 1'b0;
      req_addr_i = '0;
      req_op_i = zynq_dram_shell_pkg::op_read;
      mem_ready_i = 1'b0;
      hold_mem = 1'b0;
      model_map = '0;
      model_high = '0;
      for (int i = 0; i < 4; i++) model_reg[i] = '0;
      repeat (4) @(posedge aclk);
      reset_i <= 1'b0;

      // every offset reads 0 and held requests go nowhere
      for (int a = 0; a <= 8'h24; a += 4) read_expect("reset_read", 8'(a), 32'h0);
      @(posedge aclk);
      req_valid_i <= 1'b1;
      req_addr_i <= window;
      repeat (8) begin
         @(negedge aclk);
         check("ready_after_reset", 32'h0, 32'(req_ready_o));
      end
      @(posedge aclk);
      req_valid_i <= 1'b0;

      // strobed writes, and writes that must be ignored
      for (int i = 0; i < 24; i++) begin
         r = next_rand(seed);
         ro_addr = 8'(8'h10 + 4 * (r[7:4] % 6));
         ctrl_write(i % 4, next_rand(seed), r[3:0]);
         axil_write(ro_addr, next_rand(seed), 4'hF);
         axil_write(8'hFC, next_rand(seed), 4'hF);
         for (int k = 0; k < 4; k++) read_expect("ctrl_readback", 8'(k * 4), model_reg[k]);
         read_expect("ignored_readback", ro_addr, result_word(ro_addr));
         read_expect("unmapped_readback", 8'hFC, 32'h0);
      end

      // translation under back-pressure
      ctrl_write(0, 32'h0, 4'hF);
      ctrl_write(2, next_rand(seed), 4'hF);
      ctrl_write(1, 32'h1, 4'hF);
      ctrl_write(3, 32'h1, 4'hF);
      ctrl_write(0, 32'h1, 4'hF);
      send_burst(200);

      // no acceptance without the alloc bit
      ctrl_write(1, 32'h0, 4'hF);
      @(posedge aclk);
      req_valid_i <= 1'b1;
      repeat (8) begin
         @(negedge aclk);
         check("ready_without_alloc", 32'h0, 32'(req_ready_o));
      end
      @(posedge aclk);
      req_valid_i <= 1'b0;
      ctrl_write(1, 32'h1, 4'hF);

      // stopping the core drops the held entry
      hold_mem <= 1'b1;
      send_req(window | 32'h100, 1'b1);
      @(posedge aclk);
      req_valid_i <= 1'b0;
      ctrl_write(0, 32'h0, 4'hF);
      exp_q.delete();
      @(negedge aclk);
      check("entry_dropped", 32'h0, 32'(mem_valid_o));
      hold_mem <= 1'b0;
      check_profile("profile_cleared");

      // profiler counts only while count enable is set
      ctrl_write(0, 32'h1, 4'hF);
      send_burst(40);
      ctrl_write(3, 32'h0, 4'hF);
      send_burst(20);
      check_profile("profile");
      ctrl_write(0, 32'h0, 4'hF);
      ctrl_write(0, 32'h1, 4'hF);
      check_profile("profile_after_toggle");

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- zynq_dram_shell_top.sv
`default_nettype none

module zynq_dram_shell_top #(
   parameter logic [zynq_dram_shell_pkg::dram_addr_width-1:0] mem_limit =
      zynq_dram_shell_pkg::default_mem_limit
) (
   input  wire logic                                              aclk,
   input  wire logic                                              reset_i,
   input  wire logic [zynq_dram_shell_pkg::axil_addr_width-1:0]   s_axil_awaddr_i,
   input  wire logic                                              s_axil_awvalid_i,
   output logic                                                   s_axil_awready_o,
   input  wire logic [zynq_dram_shell_pkg::axil_data_width-1:0]   s_axil_wdata_i,
   input  wire logic [zynq_dram_shell_pkg::axil_data_width/8-1:0] s_axil_wstrb_i,
   input  wire logic                                              s_axil_wvalid_i,
   output logic                                                   s_axil_wready_o,
   output logic [1:0]                                             s_axil_bresp_o,
   output logic                                                   s_axil_bvalid_o,
   input  wire logic                                              s_axil_bready_i,
   input  wire logic [zynq_dram_shell_pkg::axil_addr_width-1:0]   s_axil_araddr_i,
   input  wire logic                                              s_axil_arvalid_i,
   output logic                                                   s_axil_arready_o,
   output logic [zynq_dram_shell_pkg::axil_data_width-1:0]        s_axil_rdata_o,
   output logic [1:0]                                             s_axil_rresp_o,
   output logic                                                   s_axil_rvalid_o,
   input  wire logic                                              s_axil_rready_i,
   input  wire logic                                              req_valid_i,
   output logic                                                   req_ready_o,
   input  wire logic [zynq_dram_shell_pkg::dram_addr_width-1:0]   req_addr_i,
   input  wire zynq_dram_shell_pkg::mem_op_e                      req_op_i,
   output logic                                                   mem_valid_o,
   input  wire logic                                              mem_ready_i,
   output logic [zynq_dram_shell_pkg::dram_addr_width-1:0]        mem_addr_o,
   output zynq_dram_shell_pkg::mem_op_e                           mem_op_o
);

   logic                                             core_reset;
   logic                                             dram_alloc;
   logic [zynq_dram_shell_pkg::dram_addr_width-1:0]  dram_base;
   logic                                             count_en;
   logic                                             accept;
   logic [zynq_dram_shell_pkg::dram_addr_width-1:0]  accept_addr;
   logic [zynq_dram_shell_pkg::region_count-1:0]     region_map;
   logic [zynq_dram_shell_pkg::high_count_width-1:0] high_count;

   zynq_dram_shell_csr csr (
      .aclk             (aclk),
      .reset_i          (reset_i),
      .s_axil_awaddr_i  (s_axil_awaddr_i),
      .s_axil_awvalid_i (s_axil_awvalid_i),
      .s_axil_awready_o (s_axil_awready_o),
      .s_axil_wdata_i   (s_axil_wdata_i),
      .s_axil_wstrb_i   (s_axil_wstrb_i),
      .s_axil_wvalid_i  (s_axil_wvalid_i),
      .s_axil_wready_o  (s_axil_wready_o),
      .s_axil_bresp_o   (s_axil_bresp_o),
      .s_axil_bvalid_o  (s_axil_bvalid_o),
      .s_axil_bready_i  (s_axil_bready_i),
      .s_axil_araddr_i  (s_axil_araddr_i),
      .s_axil_arvalid_i (s_axil_arvalid_i),
      .s_axil_arready_o (s_axil_arready_o),
      .s_axil_rdata_o   (s_axil_rdata_o),
      .s_axil_rresp_o   (s_axil_rresp_o),
      .s_axil_rvalid_o  (s_axil_rvalid_o),
      .s_axil_rready_i  (s_axil_rready_i),
      .region_map_i     (region_map),
      .high_count_i     (high_count),
      .core_reset_o     (core_reset),
      .dram_alloc_o     (dram_alloc),
      .dram_base_o      (dram_base),
      .count_en_o       (count_en)
   );

   zynq_dram_shell_xlate xlate (
      .aclk          (aclk),
      .core_reset_i  (core_reset),
      .dram_alloc_i  (dram_alloc),
      .dram_base_i   (dram_base),
      .req_valid_i   (req_valid_i),
      .req_ready_o   (req_ready_o),
      .req_addr_i    (req_addr_i),
      .req_op_i      (req_op_i),
      .mem_valid_o   (mem_valid_o),
      .mem_ready_i   (mem_ready_i),
      .mem_addr_o    (mem_addr_o),
      .mem_op_o      (mem_op_o),
      .accept_o      (accept),
      .accept_addr_o (accept_addr)
   );

   zynq_dram_shell_profiler #(
      .mem_limit (mem_limit)
   ) profiler (
      .aclk          (aclk),
      .core_reset_i  (core_reset),
      .count_en_i    (count_en),
      .accept_i      (accept),
      .accept_addr_i (accept_addr),
      .region_map_o  (region_map),
      .high_count_o  (high_count)
   );

endmodule

`default_nettype wire

//--- zynq_dram_shell_xlate.sv
`default_nettype none

module zynq_dram_shell_xlate (
   input  wire logic                                            aclk,
   input  wire logic                                            core_reset_i,
   input  wire logic                                            dram_alloc_i,
   input  wire logic [zynq_dram_shell_pkg::dram_addr_width-1:0] dram_base_i,
   input  wire logic                                            req_valid_i,
   output logic                                                 req_ready_o,
   input  wire logic [zynq_dram_shell_pkg::dram_addr_width-1:0] req_addr_i,
   input  wire zynq_dram_shell_pkg::mem_op_e                    req_op_i,
   output logic                                                 mem_valid_o,
   input  wire logic                                            mem_ready_i,
   output logic [zynq_dram_shell_pkg::dram_addr_width-1:0]      mem_addr_o,
   output zynq_dram_shell_pkg::mem_op_e                         mem_op_o,
   output logic                                                 accept_o,
   output logic [zynq_dram_shell_pkg::dram_addr_width-1:0]      accept_addr_o
);

   logic                                            entry_v_r;
   logic [zynq_dram_shell_pkg::dram_addr_width-1:0] entry_addr_r;
   zynq_dram_shell_pkg::mem_op_e                    entry_op_r;
   logic                                            accept;

   // the entry may refill in the cycle it drains, so one request per cycle
   assign req_ready_o = dram_alloc_i & ~core_reset_i & (~entry_v_r | mem_ready_i);
   assign accept      = req_valid_i & req_ready_o;

   always_ff @(posedge aclk) begin
      if (core_reset_i) begin
         entry_v_r <= 1'b0;
      end else if (accept) begin
         entry_v_r <= 1'b1;
      end else if (mem_ready_i) begin
         entry_v_r <= 1'b0;
      end
   end

   // strip the core window base and move into the host allocation
   always_ff @(posedge aclk) begin
      if (accept) begin
         entry_addr_r <= (req_addr_i ^ zynq_dram_shell_pkg::dram_window_base) + dram_base_i;
         entry_op_r   <= req_op_i;
      end
   end

   assign mem_valid_o = entry_v_r;
   assign mem_addr_o  = entry_addr_r;
   assign mem_op_o    = entry_op_r;

   // the profiler watches the untranslated core address
   assign accept_o      = accept;
   assign accept_addr_o = req_addr_i;

endmodule

`default_nettype wire
